//--- Makefile
TOP = tb_chroni

.PHONY: all run build lint clean

all: run

run: build
	./obj_dir/V$(TOP) +verilator+error+limit+100

build:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f tb.f

clean:
	rm -rf obj_dir

//--- dv/chroni_assert.sv
module chroni_assert import chroni_pkg::*; (
   input logic        vga_clk,
   input logic        reset_n,
   input vga_mode_e   vga_mode_in,
   input logic        vga_hs,
   input logic        vga_vs,
   input logic [4:0]  vga_r,
   input logic [5:0]  vga_g,
   input logic [4:0]  vga_b,
   input logic [12:0] addr_out,
   input logic        rd_req,
   input logic        rd_ack
);

   timeunit 1ns;
   timeprecision 1ps;

   int           err_cnt = 0;
   vga_mode_e    cur_mode;
   mode_timing_t t;
   logic         locked;
   logic         vs_q;
   logic [11:0]  px;
   logic [11:0]  py;
   logic [15:0]  rgb;
   logic         in_de;
   logic         in_pf;
   logic         hs_exp;
   logic         vs_exp;
   logic [15:0]  pix_exp;

   // pixel from the memory model rule, line counted from the playfield top
   function automatic logic font_bit(logic [11:0] col, logic [11:0] line);
      logic [5:0]  row;
      logic [2:0]  fl;
      logic [12:0] addr;
      logic [7:0]  code;
      logic [7:0]  bits;
      row  = line[9:4];
      fl   = line[3:1];
      addr = text_base + 13'(row) * 13'd80 + 13'(col[9:3]);
      code = addr[7:0] + 8'(row);
      bits = code ^ (8'(fl) * 8'h25);
      return bits[3'd7 - col[2:0]];
   endfunction

   assign t       = mode_table(cur_mode);
   assign rgb     = {vga_r, vga_g, vga_b};
   assign in_de   = px >= t.h_de_start && px <= t.h_de_end &&
                    py >= t.v_de_start && py <= t.v_de_end;
   assign in_pf   = px >= t.h_pf_start && px <= t.h_pf_end &&
                    py >= t.v_pf_start && py <= t.v_pf_end;
   assign hs_exp  = (px <= t.h_sync_end) ? t.h_sync_pol : !t.h_sync_pol;
   assign vs_exp  = (py <= t.v_sync_end) ? t.v_sync_pol : !t.v_sync_pol;
   assign pix_exp = font_bit(px - t.h_pf_start, py - t.v_pf_start) ?
                    text_fg_color : text_bg_color;

   // position is locked at the end of vsync, which is a clean edge even
   // right after a mode restart
   always_ff @(posedge vga_clk) begin
      vs_q <= vga_vs;
      if (!reset_n) begin
         cur_mode <= reset_mode;
         locked   <= 1'b0;
         px       <= 12'd1;
         py       <= 12'd1;
      end else if (vga_mode_in != cur_mode) begin
         cur_mode <= vga_mode_in;
         locked   <= 1'b0;
      end else if (!locked) begin
         if (vs_q == t.v_sync_pol && vga_vs != t.v_sync_pol) begin
            locked <= 1'b1;
            px     <= 12'd2;
            py     <= t.v_sync_end + 12'd1;
         end
      end else if (px == t.h_total) begin
         px <= 12'd1;
         py <= (py == t.v_total) ? 12'd1 : py + 12'd1;
      end else begin
         px <= px + 12'd1;
      end
   end

   a_reset: assert property (@(posedge vga_clk) $rose(reset_n) |->
      !rd_req && rgb == '0 &&
      vga_hs == !mode_table(mode_640x480).h_sync_pol &&
      vga_vs == !mode_table(mode_640x480).v_sync_pol)
      else begin
         err_cnt++;
         $error("outputs not idle after reset: rd_req %h rgb %h hs %h vs %h",
                $sampled(rd_req), $sampled(rgb), $sampled(vga_hs), $sampled(vga_vs));
      end

   a_hsync: assert property (@(posedge vga_clk) disable iff (!reset_n)
      locked |-> vga_hs == hs_exp)
      else begin
         err_cnt++;
         $error("mismatch vga_hs: got %h expected %h", $sampled(vga_hs), $sampled(hs_exp));
      end

   a_vsync: assert property (@(posedge vga_clk) disable iff (!reset_n)
      locked |-> vga_vs == vs_exp)
      else begin
         err_cnt++;
         $error("mismatch vga_vs: got %h expected %h", $sampled(vga_vs), $sampled(vs_exp));
      end

   a_blank: assert property (@(posedge vga_clk) disable iff (!reset_n)
      locked && !in_de |-> rgb == '0)
      else begin
         err_cnt++;
         $error("mismatch rgb: got %h expected %h", $sampled(rgb), 16'h0000);
      end

   a_border: assert property (@(posedge vga_clk) disable iff (!reset_n)
      locked && in_de && !in_pf |-> rgb == border_color)
      else begin
         err_cnt++;
         $error("mismatch rgb: got %h expected %h", $sampled(rgb), border_color);
      end

   a_pixel: assert property (@(posedge vga_clk) disable iff (!reset_n)
      locked && in_pf |-> rgb == pix_exp)
      else begin
         err_cnt++;
         $error("mismatch rgb: got %h expected %h", $sampled(rgb), $sampled(pix_exp));
      end

   a_req_hold: assert property (@(posedge vga_clk) disable iff (!reset_n)
      rd_req && !rd_ack |=> rd_req && $stable(addr_out))
      else begin
         err_cnt++;
         $error("read request dropped or address moved before the acknowledge");
      end

   a_req_drop: assert property (@(posedge vga_clk) disable iff (!reset_n)
      rd_ack |=> !rd_req)
      else begin
         err_cnt++;
         $error("read request still high in the cycle after the acknowledge");
      end

   a_addr_range: assert property (@(posedge vga_clk) disable iff (!reset_n)
      rd_req |-> addr_out < font_base + 13'h800 ||
      (addr_out >= text_base && addr_out < text_base + 13'(text_rows * text_cols)))
      else begin
         err_cnt++;
         $error("read address %h outside the font and text ranges", $sampled(addr_out));
      end

endmodule

//--- dv/tb_chroni.sv
module tb_chroni import chroni_pkg::*; ;

   timeunit 1ns;
   timeprecision 1ps;

   logic        vga_clk = 1'b0;
   logic        reset_n = 1'b0;
   vga_mode_e   vga_mode_in = mode_640x480;
   logic        vga_hs;
   logic        vga_vs;
   logic [4:0]  vga_r;
   logic [5:0]  vga_g;
   logic [4:0]  vga_b;
   logic [12:0] addr_out;
   logic [7:0]  data_in = 8'h00;
   logic        rd_req;
   logic        rd_ack = 1'b0;
   logic        ack_pending = 1'b0;
   logic [2:0]  ack_wait = 3'd0;
   logic [1:0]  idle_cnt = 2'd2;
   logic [7:0]  burst_idx = 8'd0;
   logic        burst_text = 1'b0;
   logic        read_is_text = 1'b0;

   chroni i_chroni (
      .vga_clk     (vga_clk),
      .reset_n     (reset_n),
      .vga_mode_in (vga_mode_in),
      .vga_hs      (vga_hs),
      .vga_vs      (vga_vs),
      .vga_r       (vga_r),
      .vga_g       (vga_g),
      .vga_b       (vga_b),
      .addr_out    (addr_out),
      .data_in     (data_in),
      .rd_req      (rd_req),
      .rd_ack      (rd_ack)
   );

   bind chroni chroni_assert i_chroni_assert (
      .vga_clk     (vga_clk),
      .reset_n     (reset_n),
      .vga_mode_in (vga_mode_in),
      .vga_hs      (vga_hs),
      .vga_vs      (vga_vs),
      .vga_r       (vga_r),
      .vga_g       (vga_g),
      .vga_b       (vga_b),
      .addr_out    (addr_out),
      .rd_req      (rd_req),
      .rd_ack      (rd_ack)
   );

   always #20 vga_clk = !vga_clk;

   // text codes are the low address byte plus the row, font bytes mix code and line
   // codes 128 and up put font bytes inside the text range, so the caller says which
   function automatic logic [7:0] mem_read(logic [12:0] addr, logic is_text);
      logic [7:0] row;
      if (is_text) begin
         row = 8'((addr - text_base) / 13'd80);
         return addr[7:0] + row;
      end
      return addr[10:3] ^ (8'(addr[2:0]) * 8'h25);
   endfunction

   task automatic report_failure(string why);
      $display("** FAIL **");
      $fatal(1, "%s", why);
   endtask

   // counts vsync edges of either polarity
   task automatic wait_vs_toggles(int n);
      logic last;
      last = vga_vs;
      repeat (n) begin
         @(posedge vga_clk);
         while (vga_vs == last) begin
            @(posedge vga_clk);
         end
         last = vga_vs;
      end
   endtask

   // memory with 1 to 4 cycles of acknowledge latency
   // reads of one fetch are one idle cycle apart, fetches are far apart
   always @(posedge vga_clk) begin
      if (!reset_n) begin
         rd_ack      <= 1'b0;
         ack_pending <= 1'b0;
         idle_cnt    <= 2'd2;
      end else if (rd_ack) begin
         rd_ack <= 1'b0;
      end else if (ack_pending) begin
         if (ack_wait == 3'd1) begin
            rd_ack      <= 1'b1;
            data_in     <= mem_read(addr_out, read_is_text);
            ack_pending <= 1'b0;
         end else begin
            ack_wait <= ack_wait - 3'd1;
         end
      end else if (rd_req) begin
         ack_pending <= 1'b1;
         ack_wait    <= 3'($urandom_range(4, 1));
         idle_cnt    <= 2'd0;
         if (idle_cnt == 2'd2) begin
            // a fetch with codes opens at column 0 of a row, which is 8-byte aligned
            burst_text   <= addr_out[2:0] == 3'd0;
            read_is_text <= addr_out[2:0] == 3'd0;
            burst_idx    <= 8'd1;
         end else begin
            read_is_text <= burst_text && burst_idx < 8'(text_cols);
            burst_idx    <= burst_idx + 8'd1;
         end
      end else if (idle_cnt != 2'd2) begin
         idle_cnt <= idle_cnt + 2'd1;
      end
   end

   always @(negedge vga_clk) begin
      if (i_chroni.i_chroni_assert.err_cnt != 0) begin
         report_failure("checker assertion failed");
      end
   end

   initial begin
      longint cycles;
      cycles = 3 * longint'(mode_table(mode_640x480).h_total) *
                   longint'(mode_table(mode_640x480).v_total) +
               2 * longint'(mode_table(mode_800x600).h_total) *
                   longint'(mode_table(mode_800x600).v_total) +
               2 * 100000;
      #(real'(cycles) * 1.5 * 40.0);
      report_failure("run timed out");
   end

   initial begin
      void'($urandom(32'hbd32_6192));
      repeat (10) @(posedge vga_clk);
      reset_n <= 1'b1;
      wait_vs_toggles(5);
      // switch lands in the middle of a frame
      repeat (100000) @(posedge vga_clk);
      vga_mode_in <= mode_800x600;
      wait_vs_toggles(4);
      repeat (100000) @(posedge vga_clk);
      vga_mode_in <= mode_640x480;
      wait_vs_toggles(3);
      @(posedge vga_clk);
      if (i_chroni.i_chroni_assert.err_cnt == 0) begin
         $display("** PASS **");
         $finish;
      end else begin
         report_failure("checker reported errors");
      end
   end

endmodule

//--- hdl/chroni.sv
module chroni import chroni_pkg::*; (
   input  logic        vga_clk,
   input  logic        reset_n,
   input  vga_mode_e   vga_mode_in,
   output logic        vga_hs,
   output logic        vga_vs,
   output logic [4:0]  vga_r,
   output logic [5:0]  vga_g,
   output logic [4:0]  vga_b,
   output logic [12:0] addr_out,
   input  logic [7:0]  data_in,
   output logic        rd_req,
   input  logic        rd_ack
);

   mode_timing_t  timing;
   raster_flags_t flags;
   logic          render_req;
   logic [2:0]    font_line;
   logic [5:0]    text_row;
   logic          swap;
   logic          wr_en;
   logic [6:0]    wr_col;
   logic [7:0]    wr_byte;
   logic [9:0]    rd_col;
   logic          rd_pixel;

   raster_timing i_raster_timing (
      .vga_clk     (vga_clk),
      .reset_n     (reset_n),
      .vga_mode_in (vga_mode_in),
      .timing      (timing),
      .flags       (flags),
      .render_req  (render_req),
      .font_line   (font_line),
      .text_row    (text_row)
   );

   text_fetch_fsm i_text_fetch_fsm (
      .vga_clk    (vga_clk),
      .reset_n    (reset_n),
      .render_req (render_req),
      .font_line  (font_line),
      .text_row   (text_row),
      .addr_out   (addr_out),
      .rd_req     (rd_req),
      .rd_ack     (rd_ack),
      .data_in    (data_in),
      .swap       (swap),
      .wr_en      (wr_en),
      .wr_col     (wr_col),
      .wr_byte    (wr_byte)
   );

   line_buffer i_line_buffer (
      .vga_clk  (vga_clk),
      .reset_n  (reset_n),
      .swap     (swap),
      .wr_en    (wr_en),
      .wr_col   (wr_col),
      .wr_byte  (wr_byte),
      .rd_col   (rd_col),
      .rd_pixel (rd_pixel)
   );

   pixel_output i_pixel_output (
      .vga_clk  (vga_clk),
      .reset_n  (reset_n),
      .flags    (flags),
      .timing   (timing),
      .rd_col   (rd_col),
      .rd_pixel (rd_pixel),
      .vga_hs   (vga_hs),
      .vga_vs   (vga_vs),
      .vga_r    (vga_r),
      .vga_g    (vga_g),
      .vga_b    (vga_b)
   );

endmodule

//--- hdl/chroni_pkg.sv
package chroni_pkg;

   typedef enum logic [1:0] {
      mode_640x480 = 2'd0,
      mode_800x600 = 2'd1
   } vga_mode_e;

   // counts are 1-based, ranges are inclusive
   typedef struct packed {
      logic [11:0] h_total;
      logic [11:0] h_sync_end;
      logic [11:0] h_de_start;
      logic [11:0] h_de_end;
      logic [11:0] h_pf_start;
      logic [11:0] h_pf_end;
      logic [11:0] v_total;
      logic [11:0] v_sync_end;
      logic [11:0] v_de_start;
      logic [11:0] v_de_end;
      logic [11:0] v_pf_start;
      logic [11:0] v_pf_end;
      logic        h_sync_pol;
      logic        v_sync_pol;
   } mode_timing_t;

   // raw flags, active high, polarity not yet applied
   typedef struct packed {
      logic hsync;
      logic vsync;
      logic de;
      logic pf;
      logic line_start;
      logic frame_start;
   } raster_flags_t;

   // playfield covers the whole display width, 256 lines centred
   localparam mode_timing_t timing_640x480 = '{
      h_total: 12'd800, h_sync_end: 12'd96,
      h_de_start: 12'd145, h_de_end: 12'd784,
      h_pf_start: 12'd145, h_pf_end: 12'd784,
      v_total: 12'd525, v_sync_end: 12'd2,
      v_de_start: 12'd36, v_de_end: 12'd515,
      v_pf_start: 12'd148, v_pf_end: 12'd403,
      h_sync_pol: 1'b0, v_sync_pol: 1'b0
   };

   // 80 pixel side borders, 512 lines centred
   localparam mode_timing_t timing_800x600 = '{
      h_total: 12'd1056, h_sync_end: 12'd128,
      h_de_start: 12'd217, h_de_end: 12'd1016,
      h_pf_start: 12'd297, h_pf_end: 12'd936,
      v_total: 12'd628, v_sync_end: 12'd4,
      v_de_start: 12'd28, v_de_end: 12'd627,
      v_pf_start: 12'd72, v_pf_end: 12'd583,
      h_sync_pol: 1'b1, v_sync_pol: 1'b1
   };

   function automatic mode_timing_t mode_table(vga_mode_e mode);
      case (mode)
         mode_800x600: return timing_800x600;
         default:      return timing_640x480;
      endcase
   endfunction

   localparam vga_mode_e    reset_mode   = mode_640x480;
   localparam mode_timing_t reset_timing = mode_table(reset_mode);

   // rgb565
   localparam logic [15:0] border_color  = 16'h10A3;
   localparam logic [15:0] text_bg_color = 16'h29AC;
   localparam logic [15:0] text_fg_color = 16'hF75B;

   localparam int text_cols  = 80;
   localparam int text_rows  = 32;
   localparam int font_lines = 8;
   localparam int pf_width   = 640;

   localparam logic [12:0] text_base = 13'h0400;
   localparam logic [12:0] font_base = 13'h0000;

endpackage

//--- hdl/line_buffer.sv
module line_buffer import chroni_pkg::*; (
   input  logic       vga_clk,
   input  logic       reset_n,
   input  logic       swap,
   input  logic       wr_en,
   input  logic [6:0] wr_col,
   input  logic [7:0] wr_byte,
   input  logic [9:0] rd_col,
   output logic       rd_pixel
);

   // ascending bit order puts the byte msb on the leftmost pixel
   logic [0:pf_width-1] rows [2];
   logic                front;
   logic [9:0]          wr_base;

   assign wr_base = {wr_col, 3'b000};

   always_ff @(posedge vga_clk) begin
      if (!reset_n) begin
         front <= 1'b0;
      end else if (swap) begin
         front <= !front;
      end
   end

   // writes always go to the back row
   always_ff @(posedge vga_clk) begin
      if (wr_en) begin
         rows[!front][wr_base +: 8] <= wr_byte;
      end
   end

   always_ff @(posedge vga_clk) begin
      rd_pixel <= rows[front][rd_col];
   end

endmodule

//--- hdl/pixel_output.sv
module pixel_output import chroni_pkg::*; (
   input  logic          vga_clk,
   input  logic          reset_n,
   input  raster_flags_t flags,
   input  mode_timing_t  timing,
   output logic [9:0]    rd_col,
   input  logic          rd_pixel,
   output logic          vga_hs,
   output logic          vga_vs,
   output logic [4:0]    vga_r,
   output logic [5:0]    vga_g,
   output logic [4:0]    vga_b
);

   raster_flags_t flags_d;
   logic          h_pol_q, v_pol_q;
   logic          h_pol, v_pol;
   logic [15:0]   color;

   // timing switches a few cycles ahead of the delayed flags, so polarity
   // follows the frame start as it reaches this stage
   assign h_pol = flags_d.frame_start ? timing.h_sync_pol : h_pol_q;
   assign v_pol = flags_d.frame_start ? timing.v_sync_pol : v_pol_q;

   always_comb begin
      if (!flags_d.de) begin
         color = '0;
      end else if (!flags_d.pf) begin
         color = border_color;
      end else begin
         color = rd_pixel ? text_fg_color : text_bg_color;
      end
   end

   always_ff @(posedge vga_clk) begin
      if (!reset_n || flags.line_start) begin
         rd_col <= '0;
      end else if (flags.pf && rd_col != 10'(pf_width - 1)) begin
         rd_col <= rd_col + 10'd1;
      end
   end

   always_ff @(posedge vga_clk) begin
      if (!reset_n) begin
         flags_d <= '0;
         h_pol_q <= reset_timing.h_sync_pol;
         v_pol_q <= reset_timing.v_sync_pol;
         vga_hs  <= !reset_timing.h_sync_pol;
         vga_vs  <= !reset_timing.v_sync_pol;
         {vga_r, vga_g, vga_b} <= '0;
      end else begin
         flags_d <= flags;
         h_pol_q <= h_pol;
         v_pol_q <= v_pol;
         vga_hs  <= h_pol ? flags_d.hsync : !flags_d.hsync;
         vga_vs  <= v_pol ? flags_d.vsync : !flags_d.vsync;
         {vga_r, vga_g, vga_b} <= color;
      end
   end

endmodule

//--- hdl/raster_timing.sv
module raster_timing import chroni_pkg::*; (
   input  logic          vga_clk,
   input  logic          reset_n,
   input  vga_mode_e     vga_mode_in,
   output mode_timing_t  timing,
   output raster_flags_t flags,
   output logic          render_req,
   output logic [2:0]    font_line,
   output logic [5:0]    text_row
);

   vga_mode_e   mode;
   logic [11:0] x_cnt;
   logic [11:0] y_cnt;
   logic        at_frame_start;
   logic        mode_change;
   logic        line_end;
   logic        in_render;
   logic        dbl_scan;
   logic        h_de, v_de, h_pf, v_pf;

   assign at_frame_start = (x_cnt == 12'd1) && (y_cnt == 12'd1);
   assign mode_change    = vga_mode_in != mode;
   assign line_end       = x_cnt == timing.h_total;

   assign h_de = (x_cnt >= timing.h_de_start) && (x_cnt <= timing.h_de_end);
   assign v_de = (y_cnt >= timing.v_de_start) && (y_cnt <= timing.v_de_end);
   assign h_pf = (x_cnt >= timing.h_pf_start) && (x_cnt <= timing.h_pf_end);
   assign v_pf = (y_cnt >= timing.v_pf_start) && (y_cnt <= timing.v_pf_end);

   // fetch window runs from three lines before the playfield to two before its end
   assign in_render = (y_cnt >= timing.v_pf_start - 12'd3) &&
                      (y_cnt <= timing.v_pf_end - 12'd2);

   assign render_req = line_end && in_render && !dbl_scan;

   // mode only changes at a frame start
   always_ff @(posedge vga_clk) begin
      if (!reset_n) begin
         mode   <= reset_mode;
         timing <= reset_timing;
      end else if (at_frame_start) begin
         mode   <= vga_mode_in;
         timing <= mode_table(vga_mode_in);
      end
   end

   always_ff @(posedge vga_clk) begin
      if (!reset_n || (mode_change && !at_frame_start)) begin
         x_cnt <= 12'd1;
         y_cnt <= 12'd1;
      end else if (line_end) begin
         x_cnt <= 12'd1;
         y_cnt <= (y_cnt == timing.v_total) ? 12'd1 : y_cnt + 12'd1;
      end else begin
         x_cnt <= x_cnt + 12'd1;
      end
   end

   always_ff @(posedge vga_clk) begin
      if (!reset_n) begin
         flags <= '0;
      end else begin
         flags.hsync       <= x_cnt <= timing.h_sync_end;
         flags.vsync       <= y_cnt <= timing.v_sync_end;
         flags.de          <= h_de && v_de;
         flags.pf          <= h_pf && v_pf;
         flags.line_start  <= x_cnt == 12'd1;
         flags.frame_start <= at_frame_start;
      end
   end

   // each font line is shown twice, so a fetch is needed every second line
   always_ff @(posedge vga_clk) begin
      if (!reset_n || at_frame_start) begin
         dbl_scan  <= 1'b0;
         font_line <= '0;
         text_row  <= '0;
      end else begin
         if (line_end && in_render) begin
            dbl_scan <= !dbl_scan;
         end
         if (render_req) begin
            font_line <= font_line + 3'd1;
            if (font_line == 3'(font_lines - 1)) begin
               text_row <= text_row + 6'd1;
            end
         end
      end
   end

endmodule

//--- hdl/text_fetch_fsm.sv
module text_fetch_fsm import chroni_pkg::*; (
   input  logic        vga_clk,
   input  logic        reset_n,
   input  logic        render_req,
   input  logic [2:0]  font_line,
   input  logic [5:0]  text_row,
   output logic [12:0] addr_out,
   output logic        rd_req,
   input  logic        rd_ack,
   input  logic [7:0]  data_in,
   output logic        swap,
   output logic        wr_en,
   output logic [6:0]  wr_col,
   output logic [7:0]  wr_byte
);

   typedef enum logic [2:0] {
      idle,
      text_read,
      text_wait,
      font_read,
      font_wait
   } fetch_state_e;

   fetch_state_e state;
   logic [6:0]   col;
   logic [2:0]   line_q;
   logic [5:0]   row_q;
   logic [7:0]   code_store [text_cols];
   logic [12:0]  text_addr;
   logic [12:0]  font_addr;
   logic         last_col;

   assign text_addr = text_base + 13'(row_q) * 13'(text_cols) + 13'(col);
   assign font_addr = font_base + {2'b00, code_store[col], line_q};
   assign last_col  = col == 7'(text_cols - 1);

   always_ff @(posedge vga_clk) begin
      if (!reset_n) begin
         state    <= idle;
         col      <= '0;
         addr_out <= '0;
         rd_req   <= 1'b0;
         swap     <= 1'b0;
         wr_en    <= 1'b0;
      end else begin
         swap  <= 1'b0;
         wr_en <= 1'b0;
         if (render_req) begin
            // a new line pair always restarts the fetch
            swap   <= 1'b1;
            col    <= '0;
            rd_req <= 1'b0;
            if (text_row >= 6'(text_rows)) begin
               state <= idle;
            end else if (font_line == 3'd0) begin
               state <= text_read;
            end else begin
               state <= font_read;
            end
         end else begin
            case (state)
               text_read: begin
                  addr_out <= text_addr;
                  rd_req   <= 1'b1;
                  state    <= text_wait;
               end
               text_wait: begin
                  if (rd_ack) begin
                     rd_req          <= 1'b0;
                     code_store[col] <= data_in;
                     if (last_col) begin
                        col   <= '0;
                        state <= font_read;
                     end else begin
                        col   <= col + 7'd1;
                        state <= text_read;
                     end
                  end
               end
               font_read: begin
                  addr_out <= font_addr;
                  rd_req   <= 1'b1;
                  state    <= font_wait;
               end
               font_wait: begin
                  if (rd_ack) begin
                     rd_req <= 1'b0;
                     wr_en  <= 1'b1;
                     if (last_col) begin
                        state <= idle;
                     end else begin
                        col   <= col + 7'd1;
                        state <= font_read;
                     end
                  end
               end
               default: begin
                  rd_req <= 1'b0;
               end
            endcase
         end
      end
   end

   // payload of the buffer write, qualified by wr_en
   always_ff @(posedge vga_clk) begin
      if (render_req) begin
         line_q <= font_line;
         row_q  <= text_row;
      end
      if (state == font_wait && rd_ack) begin
         wr_col  <= col;
         wr_byte <= data_in;
      end
   end

endmodule

//--- tb.f
hdl/chroni_pkg.sv
hdl/raster_timing.sv
hdl/text_fetch_fsm.sv
hdl/line_buffer.sv
hdl/pixel_output.sv
hdl/chroni.sv
dv/chroni_assert.sv
dv/tb_chroni.sv
